//--- rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data and address width
`define RV_XLEN 32

// rv32e register count, x0..x15
`define RV_NREG 16

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// data memory depth in words, indexed by addr[..:2]
`define RV_DMEM_WORDS 256

`endif

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

	// bit positions in the one-hot opcode class
	typedef enum logic [3:0] {
		OP_LUI,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_BRANCH,
		OP_LOAD,
		OP_STORE,
		OP_IMM,
		OP_REG,
		OP_SYSTEM,
		OP_FENCE
	} op_idx_e;

	typedef logic [OP_FENCE:0] op_class_t;

	typedef enum logic [2:0] {
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J,
		IMM_NONE
	} imm_fmt_e;

	typedef enum logic [1:0] {ALU_ADD, ALU_XOR, ALU_OR, ALU_AND} alu_op_e;

endpackage

`default_nettype wire

//--- rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_fetch (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                decode_ready,
	input  logic                retire,
	input  logic [`RV_XLEN-1:0] next_pc,
	input  logic                halt,
	input  logic [`RV_XLEN-1:0] imem_data,
	output logic                imem_en,
	output logic [`RV_XLEN-1:0] imem_addr,
	output logic                fetch_valid,
	output logic [`RV_XLEN-1:0] inst,
	output logic [`RV_XLEN-1:0] inst_pc
);

	typedef enum logic [1:0] {S_REQ, S_PRESENT, S_WAIT} state_e;

	state_e              state;
	logic [`RV_XLEN-1:0] pc_q;
	logic [`RV_XLEN-1:0] inst_q;
	logic                resp_q; // memory word is on imem_data now

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request / present / wait
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state       <= S_REQ;
			pc_q        <= `RV_RESET_PC;
			imem_en     <= 1'b0;
			fetch_valid <= 1'b0;
			resp_q      <= 1'b0;
		end else begin
			resp_q <= imem_en;
			case (state)
				S_REQ: begin // first request out of reset
					imem_en <= 1'b1;
					state   <= S_PRESENT;
				end
				S_PRESENT: begin
					if (imem_en) begin
						imem_en     <= 1'b0;
						fetch_valid <= 1'b1;
					end else if (fetch_valid && decode_ready) begin
						fetch_valid <= 1'b0;
						state       <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (retire && !halt) begin
						pc_q    <= next_pc;
						imem_en <= 1'b1;
						state   <= S_PRESENT;
					end
				end
				default: state <= S_WAIT;
			endcase
		end
	end

	// hold the word in case decode stalls
	always_ff @(posedge clock) begin
		if (resp_q) inst_q <= imem_data;
	end

	assign inst      = resp_q ? imem_data : inst_q;
	assign imem_addr = pc_q;
	assign inst_pc   = pc_q;

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic [$clog2(`RV_NREG)-1:0] rs1,
	input  logic [$clog2(`RV_NREG)-1:0] rs2,
	input  logic                        wen,
	input  logic [$clog2(`RV_NREG)-1:0] waddr,
	input  logic [`RV_XLEN-1:0]         wdata,
	output logic [`RV_XLEN-1:0]         rdata1,
	output logic [`RV_XLEN-1:0]         rdata2
);

	logic [`RV_XLEN-1:0] regs [`RV_NREG];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin // x0 never written
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_decode import rv_pkg::*; (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        fetch_valid,
	input  logic [`RV_XLEN-1:0]         inst,
	input  logic [`RV_XLEN-1:0]         inst_pc,
	input  logic [`RV_XLEN-1:0]         rdata1,
	input  logic [`RV_XLEN-1:0]         rdata2,
	input  logic                        exu_ready,
	output logic                        decode_ready,
	output logic [$clog2(`RV_NREG)-1:0] rs1,
	output logic [$clog2(`RV_NREG)-1:0] rs2,
	output logic                        exu_valid,
	output logic [`RV_XLEN-1:0]         pc_q,
	output op_class_t                   op_class,
	output logic [2:0]                  funct3,
	output logic [6:0]                  funct7,
	output logic [$clog2(`RV_NREG)-1:0] rd,
	output logic [`RV_XLEN-1:0]         src1_q,
	output logic [`RV_XLEN-1:0]         src2_q,
	output logic [`RV_XLEN-1:0]         imm,
	output logic                        reg_wen,
	output logic                        halt_req
);

	localparam int RA = $clog2(`RV_NREG);

	logic [6:0]          opcode;
	op_class_t           cls_d;
	imm_fmt_e            fmt_d;
	logic [`RV_XLEN-1:0] imm_d;
	logic                wen_d;
	logic                take;

	assign take = fetch_valid & decode_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake flags
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			decode_ready <= 1'b1;
			exu_valid    <= 1'b0;
		end else begin
			// ready drops on accept, back once execute has taken it
			decode_ready <= (decode_ready & ~fetch_valid) |
					(~decode_ready & exu_valid & exu_ready);
			exu_valid    <= (exu_valid & ~exu_ready) | (~exu_valid & take);
		end
	end

	assign opcode = inst[6:0];
	assign rs1    = inst[15 +: RA];
	assign rs2    = inst[20 +: RA];

	always_comb begin
		cls_d            = '0;
		cls_d[OP_LUI]    = (opcode == 7'b0110111);
		cls_d[OP_AUIPC]  = (opcode == 7'b0010111);
		cls_d[OP_JAL]    = (opcode == 7'b1101111);
		cls_d[OP_JALR]   = (opcode == 7'b1100111);
		cls_d[OP_BRANCH] = (opcode == 7'b1100011);
		cls_d[OP_LOAD]   = (opcode == 7'b0000011);
		cls_d[OP_STORE]  = (opcode == 7'b0100011);
		cls_d[OP_IMM]    = (opcode == 7'b0010011);
		cls_d[OP_REG]    = (opcode == 7'b0110011);
		cls_d[OP_SYSTEM] = (opcode == 7'b1110011);
		cls_d[OP_FENCE]  = (opcode == 7'b0001111);
	end

	always_comb begin
		if (cls_d[OP_JALR] | cls_d[OP_LOAD] | cls_d[OP_IMM])
			fmt_d = IMM_I;
		else if (cls_d[OP_STORE])
			fmt_d = IMM_S;
		else if (cls_d[OP_BRANCH])
			fmt_d = IMM_B;
		else if (cls_d[OP_LUI] | cls_d[OP_AUIPC])
			fmt_d = IMM_U;
		else if (cls_d[OP_JAL])
			fmt_d = IMM_J;
		else
			fmt_d = IMM_NONE; // reg, system, fence
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// immediate build
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (fmt_d)
			IMM_I:   imm_d = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
			IMM_S:   imm_d = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
			IMM_B:   imm_d = {{(`RV_XLEN-12){inst[31]}}, inst[7], inst[30:25],
					inst[11:8], 1'b0};
			IMM_U:   imm_d = {inst[31:12], 12'b0};
			IMM_J:   imm_d = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20],
					inst[30:21], 1'b0};
			default: imm_d = '0;
		endcase
	end

	assign wen_d = (fmt_d == IMM_I) | (fmt_d == IMM_U) | (fmt_d == IMM_J) | cls_d[OP_REG];

	always_ff @(posedge clock) begin
		if (take) begin
			pc_q     <= inst_pc;
			op_class <= cls_d;
			funct3   <= inst[14:12];
			funct7   <= inst[31:25];
			rd       <= inst[7 +: RA];
			src1_q   <= rdata1;
			src2_q   <= rdata2;
			imm      <= imm_d;
			reg_wen  <= wen_d;
			halt_req <= (inst == 32'h0000_0073); // ecall
		end
	end

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_execute import rv_pkg::*; (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        exu_valid,
	input  logic [`RV_XLEN-1:0]         pc_q,
	input  op_class_t                   op_class,
	input  logic [2:0]                  funct3,
	input  logic [6:0]                  funct7,
	input  logic [$clog2(`RV_NREG)-1:0] rd,
	input  logic [`RV_XLEN-1:0]         src1_q,
	input  logic [`RV_XLEN-1:0]         src2_q,
	input  logic [`RV_XLEN-1:0]         imm,
	input  logic                        reg_wen,
	input  logic                        halt_req,
	output logic                        exu_ready,
	output logic                        wen,
	output logic [$clog2(`RV_NREG)-1:0] waddr,
	output logic [`RV_XLEN-1:0]         wdata,
	output logic                        retire,
	output logic [`RV_XLEN-1:0]         retire_pc,
	output logic [`RV_XLEN-1:0]         next_pc,
	output logic                        halt
);

	localparam int DA = $clog2(`RV_DMEM_WORDS);

	logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];

	alu_op_e             alu_op;
	logic                sub;
	logic                br_take;
	logic                fire;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_res;
	logic [`RV_XLEN-1:0] link;
	logic [`RV_XLEN-1:0] target;
	logic [`RV_XLEN-1:0] result;
	logic [DA-1:0]       dmem_idx;

	assign exu_ready = ~halt; // idle until ecall
	assign fire      = exu_valid & exu_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// alu
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (funct3)
			3'b100:  alu_op = ALU_XOR;
			3'b110:  alu_op = ALU_OR;
			3'b111:  alu_op = ALU_AND;
			default: alu_op = ALU_ADD;
		endcase
		if (!(op_class[OP_IMM] | op_class[OP_REG]))
			alu_op = ALU_ADD; // address and lui/auipc sums
	end

	assign sub  = op_class[OP_REG] & funct7[5] & (funct3 == 3'b000);
	assign op_a = op_class[OP_AUIPC] ? pc_q : (op_class[OP_LUI] ? '0 : src1_q);
	assign op_b = op_class[OP_REG] ? src2_q : imm;

	always_comb begin
		case (alu_op)
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_AND: alu_res = op_a & op_b;
			default: alu_res = sub ? op_a - op_b : op_a + op_b;
		endcase
	end

	assign link    = pc_q + `RV_XLEN'(4);
	assign br_take = op_class[OP_BRANCH] & ((src1_q == src2_q) ^ funct3[0]); // bne flips

	always_comb begin
		if (op_class[OP_JALR])
			target = {alu_res[`RV_XLEN-1:1], 1'b0};
		else if (op_class[OP_JAL] | br_take)
			target = pc_q + imm;
		else
			target = link;
	end

	assign dmem_idx = alu_res[2 +: DA];

	always_comb begin
		if (op_class[OP_LOAD])
			result = dmem[dmem_idx];
		else if (op_class[OP_JAL] | op_class[OP_JALR])
			result = link;
		else
			result = alu_res;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory, writeback, retire
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock) begin
		if (fire && op_class[OP_STORE]) dmem[dmem_idx] <= src2_q; // sw only
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			retire <= 1'b0;
			wen    <= 1'b0;
			halt   <= 1'b0;
		end else begin
			retire <= fire;
			wen    <= fire & reg_wen;
			if (fire && halt_req) halt <= 1'b1; // sticky
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			waddr     <= rd;
			wdata     <= result;
			retire_pc <= pc_q;
			next_pc   <= target;
		end
	end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_core import rv_pkg::*; (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic [`RV_XLEN-1:0]         imem_data,
	output logic                        imem_en,
	output logic [`RV_XLEN-1:0]         imem_addr,
	output logic                        retire,
	output logic [`RV_XLEN-1:0]         retire_pc,
	output logic [$clog2(`RV_NREG)-1:0] retire_rd,
	output logic                        retire_wen,
	output logic [`RV_XLEN-1:0]         retire_data,
	output logic                        halt
);

	// fetch to decode
	logic                        fetch_valid;
	logic                        decode_ready;
	logic [`RV_XLEN-1:0]         inst;
	logic [`RV_XLEN-1:0]         inst_pc;

	// decode to regfile
	logic [$clog2(`RV_NREG)-1:0] rs1;
	logic [$clog2(`RV_NREG)-1:0] rs2;
	logic [`RV_XLEN-1:0]         rdata1;
	logic [`RV_XLEN-1:0]         rdata2;

	// decode to execute
	logic                        exu_valid;
	logic                        exu_ready;
	logic [`RV_XLEN-1:0]         pc_q;
	op_class_t                   op_class;
	logic [2:0]                  funct3;
	logic [6:0]                  funct7;
	logic [$clog2(`RV_NREG)-1:0] rd;
	logic [`RV_XLEN-1:0]         src1_q;
	logic [`RV_XLEN-1:0]         src2_q;
	logic [`RV_XLEN-1:0]         imm;
	logic                        reg_wen;
	logic                        halt_req;

	logic [`RV_XLEN-1:0]         next_pc;

	rv_fetch rv_fetch_i (
		.clock(clock), .rst_n(rst_n),
		.decode_ready(decode_ready), .retire(retire), .next_pc(next_pc), .halt(halt),
		.imem_data(imem_data), .imem_en(imem_en), .imem_addr(imem_addr),
		.fetch_valid(fetch_valid), .inst(inst), .inst_pc(inst_pc)
	);

	rv_decode rv_decode_i (
		.clock(clock), .rst_n(rst_n),
		.fetch_valid(fetch_valid), .inst(inst), .inst_pc(inst_pc),
		.rdata1(rdata1), .rdata2(rdata2), .exu_ready(exu_ready),
		.decode_ready(decode_ready), .rs1(rs1), .rs2(rs2), .exu_valid(exu_valid),
		.pc_q(pc_q), .op_class(op_class), .funct3(funct3), .funct7(funct7), .rd(rd),
		.src1_q(src1_q), .src2_q(src2_q), .imm(imm), .reg_wen(reg_wen),
		.halt_req(halt_req)
	);

	// writeback port doubles as the retire observation
	rv_regfile rv_regfile_i (
		.clock(clock), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
		.wen(retire_wen), .waddr(retire_rd), .wdata(retire_data),
		.rdata1(rdata1), .rdata2(rdata2)
	);

	rv_execute rv_execute_i (
		.clock(clock), .rst_n(rst_n),
		.exu_valid(exu_valid), .pc_q(pc_q), .op_class(op_class), .funct3(funct3),
		.funct7(funct7), .rd(rd), .src1_q(src1_q), .src2_q(src2_q), .imm(imm),
		.reg_wen(reg_wen), .halt_req(halt_req), .exu_ready(exu_ready),
		.wen(retire_wen), .waddr(retire_rd), .wdata(retire_data),
		.retire(retire), .retire_pc(retire_pc), .next_pc(next_pc), .halt(halt)
	);

endmodule

`default_nettype wire

//--- rv_core_model.svh
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program generator and instruction set model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int K_ALUI = 0, K_ALUR = 1, K_LUI = 2, K_AUIPC = 3, K_LW = 4, K_SW = 5;
localparam int K_BR = 6, K_JAL = 7, K_FENCE = 8, K_PAIR = 9, K_SETUP = 10;
localparam int K_JALR = 11, K_ECALL = 12, K_INIT = 13;

logic [31:0] prog [PROG_LEN];
int          kind [PROG_LEN];
logic [31:0] rng_state = SEED;

// architectural state
logic [31:0] m_pc;
logic [31:0] m_regs [16];
logic [31:0] m_dmem [`RV_DMEM_WORDS];
logic        m_halted;

function logic [31:0] xorshift32();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

function logic [31:0] enc_i(logic [11:0] imm, logic [3:0] rs1, logic [2:0] f3,
		logic [3:0] rd, logic [6:0] op);
	return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
endfunction

function logic [31:0] enc_b(logic [12:0] o, logic [3:0] rs2, logic [3:0] rs1, logic f3_0);
	return {o[12], o[10:5], 1'b0, rs2, 1'b0, rs1, 2'b00, f3_0, o[4:1], o[11], 7'b1100011};
endfunction

// forward hop from slot j that never lands on a bare jalr
function int fwd_offset(int j);
	int off;
	off = 1 + int'(xorshift32() % 3);
	if (j + off > PROG_LEN - 1) off = PROG_LEN - 1 - j;
	if (kind[j + off] == K_JALR) off = (off == 1) ? 2 : off - 1;
	return off;
endfunction

task gen_program();
	int          i;
	int          t;
	logic [31:0] r;
	logic [3:0]  rd;
	logic [3:0]  rs1;
	logic [3:0]  rs2;
	logic [2:0]  f3;
	logic [11:0] addr;
	i = 8; // words 0..7 store zeros so every later lw reads known data
	for (int k = 0; k < 8; k++) kind[k] = K_INIT;
	while (i < PROG_LEN - 1) begin
		t = int'(xorshift32() % 10);
		if (t == K_PAIR && i <= PROG_LEN - 3) begin
			kind[i]     = K_SETUP;
			kind[i + 1] = K_JALR;
			i += 2;
		end else begin
			kind[i] = (t == K_PAIR) ? K_ALUI : t;
			i++;
		end
	end
	kind[PROG_LEN - 1] = K_ECALL;
	for (int k = 0; k < PROG_LEN; k++) begin
		r    = xorshift32();
		rd   = 4'(r % 15); // x15 kept for jalr targets
		rs1  = r[11:8];
		rs2  = r[15:12];
		f3   = (r[17:16] == 2'd0) ? 3'd0 : {1'b1, r[17:16] == 2'd1 ? 2'b00 : r[17:16]};
		addr = 12'((r[22:20]) * 4);
		case (kind[k])
			K_ALUI:  prog[k] = enc_i(r[31:20], rs1, f3, rd, 7'b0010011);
			K_ALUR:  prog[k] = {1'b0, f3 == 3'd0 && r[31], 5'b0, 1'b0, rs2, 1'b0, rs1,
					f3, 1'b0, rd, 7'b0110011};
			K_LUI:   prog[k] = {r[31:12], 1'b0, rd, 7'b0110111};
			K_AUIPC: prog[k] = {r[31:12], 1'b0, rd, 7'b0010111};
			K_LW:    prog[k] = enc_i(addr, 4'd0, 3'b010, rd, 7'b0000011);
			K_SW:    prog[k] = {addr[11:5], 1'b0, rs2, 5'b0, 3'b010, addr[4:0], 7'b0100011};
			K_INIT:  prog[k] = {7'b0, 10'b0, 3'b010, 5'(k * 4), 7'b0100011};
			K_BR:    prog[k] = enc_b(13'(fwd_offset(k) * 4), rs2, rs1, r[24]);
			K_JAL:   begin
				t       = fwd_offset(k) * 4;
				prog[k] = {t[20], t[10:1], t[11], t[19:12], 1'b0, rd, 7'b1101111};
			end
			K_FENCE: prog[k] = 32'h0000_100f;
			K_SETUP: prog[k] = enc_i(12'((k + 1 + fwd_offset(k + 1)) * 4), 4'd0, 3'd0,
					4'd15, 7'b0010011);
			K_JALR:  prog[k] = enc_i({11'b0, r[25]}, 4'd15, 3'd0, rd, 7'b1100111);
			default: prog[k] = 32'h0000_0073; // ecall
		endcase
	end
endtask

function logic [31:0] ref_alu(logic [2:0] f3, logic [31:0] a, logic [31:0] b, logic sub);
	alu_op_e op;
	case (f3)
		3'b100:  op = ALU_XOR;
		3'b110:  op = ALU_OR;
		3'b111:  op = ALU_AND;
		default: op = ALU_ADD;
	endcase
	case (op)
		ALU_XOR: return a ^ b;
		ALU_OR:  return a | b;
		ALU_AND: return a & b;
		default: return sub ? a - b : a + b;
	endcase
endfunction

task model_reset();
	m_pc     = `RV_RESET_PC;
	m_halted = 1'b0;
	for (int k = 0; k < 16; k++) m_regs[k] = '0;
	for (int k = 0; k < `RV_DMEM_WORDS; k++) m_dmem[k] = '0;
endtask

// steps one instruction and gives what retire should show
function void model_step(output logic [31:0] e_pc, output logic [3:0] e_rd,
		output logic e_wen, output logic [31:0] e_data);
	logic [31:0] in;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] ii;
	logic [31:0] nxt;
	int          idx;
	in     = prog[m_pc[7:2]];
	a      = m_regs[in[18:15]];
	b      = m_regs[in[23:20]];
	ii     = {{20{in[31]}}, in[31:20]};
	nxt    = m_pc + 4;
	e_pc   = m_pc;
	e_rd   = in[10:7];
	e_wen  = 1'b0;
	e_data = '0;
	idx    = int'(((a + ii) >> 2) % `RV_DMEM_WORDS);
	case (in[6:0])
		7'b0110111: begin
			e_wen  = 1;
			e_data = {in[31:12], 12'b0};
		end
		7'b0010111: begin
			e_wen  = 1;
			e_data = m_pc + {in[31:12], 12'b0};
		end
		7'b1101111: begin
			e_wen  = 1;
			e_data = m_pc + 4;
			nxt    = m_pc + {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
		end
		7'b1100111: begin
			e_wen  = 1;
			e_data = m_pc + 4;
			nxt    = (a + ii) & ~32'd1;
		end
		7'b1100011: if ((a == b) ^ in[12])
			nxt = m_pc + {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
		7'b0000011: begin
			e_wen  = 1;
			e_data = m_dmem[idx];
		end
		7'b0100011: m_dmem[((a + {{20{in[31]}}, in[31:25], in[11:7]}) >> 2) % 256] = b;
		7'b0010011: begin
			e_wen  = 1;
			e_data = ref_alu(in[14:12], a, ii, 1'b0);
		end
		7'b0110011: begin
			e_wen  = 1;
			e_data = ref_alu(in[14:12], a, b, in[30] && in[14:12] == 3'd0);
		end
		7'b1110011: m_halted = 1'b1;
		default: ; // fence.i
	endcase
	if (e_wen && e_rd != 0) m_regs[e_rd] = e_data; // x0 stays zero
	m_pc = nxt;
endfunction

`endif

//--- rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb import rv_pkg::*; ();

	localparam int          PROG_LEN = 64;
	localparam logic [31:0] SEED     = 32'd75997;

	logic        clock;
	logic        rst_n;
	logic [31:0] imem_data;
	logic        imem_en;
	logic [31:0] imem_addr;
	logic        retire;
	logic [31:0] retire_pc;
	logic [3:0]  retire_rd;
	logic        retire_wen;
	logic [31:0] retire_data;
	logic        halt;

	logic [31:0] req_addr;
	logic [31:0] e_pc;
	logic [31:0] e_data;
	logic [31:0] expect_addr;
	logic [3:0]  e_rd;
	logic        e_wen;
	logic        fetch_pending;
	int          retired;
	int          exp_count;
	int          idle;

	`include "rv_core_model.svh"

	rv_core rv_core_i (
		.clock(clock), .rst_n(rst_n), .imem_data(imem_data), .imem_en(imem_en),
		.imem_addr(imem_addr), .retire(retire), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_wen(retire_wen), .retire_data(retire_data),
		.halt(halt)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	// synchronous read with the word valid 1 ns after the edge
	always @(posedge clock) begin
		if (imem_en) begin
			req_addr = imem_addr;
			#1 imem_data <= prog[req_addr[7:2]];
		end
	end

	task check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task fail_with(string what);
		assert (0) else begin
			$display("at %0t: %s", $time, what);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task compare_retire();
		model_step(e_pc, e_rd, e_wen, e_data);
		check_value("retire_pc", retire_pc, e_pc);
		check_value("retire_wen", 32'(retire_wen), 32'(e_wen));
		if (e_wen) begin
			check_value("retire_rd", 32'(retire_rd), 32'(e_rd));
			check_value("retire_data", retire_data, e_data);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		rst_n     = 1'b0;
		imem_data = '0;
		gen_program();
		model_reset();
		exp_count = 0;
		while (!m_halted && exp_count < 4 * PROG_LEN) begin
			model_step(e_pc, e_rd, e_wen, e_data);
			exp_count++;
		end
		model_reset();

		repeat (10) begin
			@(posedge clock);
			#1;
			check_value("retire", 32'(retire), 0);
			check_value("halt", 32'(halt), 0);
		end
		rst_n = 1'b1;

		expect_addr   = `RV_RESET_PC;
		fetch_pending = 1'b1;
		retired       = 0;
		idle          = 0;
		while (!m_halted) begin
			@(negedge clock);
			idle++;
			if (idle > 40) fail_with("no instruction retired within 40 cycles");
			if (imem_en) begin
				if (!fetch_pending) fail_with("instruction fetch before the previous retire");
				check_value("imem_addr", imem_addr, expect_addr);
				fetch_pending = 1'b0;
			end
			if (retire) begin
				idle = 0;
				retired++;
				compare_retire();
				expect_addr   = m_pc;
				fetch_pending = 1'b1;
			end
		end
		check_value("halt", 32'(halt), 1);

		// core must stay parked
		repeat (20) begin
			@(negedge clock);
			if (retire) retired++;
			check_value("halt", 32'(halt), 1);
			check_value("imem_en", 32'(imem_en), 0);
		end
		check_value("retire count", 32'(retired), 32'(exp_count));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_core.sv
rv_core_tb.sv

//--- Makefile
SIM    = verilator
FLAGS  = --binary --timing
TOP    = rv_core_tb
FLIST  = rv_core.f
OBJDIR = obj_dir

SRCS = $(filter-out +%,$(shell cat $(FLIST)))
HDRS = $(wildcard *.svh)
BIN  = $(OBJDIR)/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

clean:
	rm -rf $(OBJDIR)
